/* bench/tb_vid_framebuf.sv */
`default_nettype none

module tb_vid_framebuf;

	localparam int AW = 24;
	localparam int DW = 32;
	localparam int PW = 8;
	localparam int LGFRAME = 11;
	localparam int LGFIFO = 6;
	// Pixels per bus word
	localparam int NPIX = DW / PW;
	// Burst limit, LGBURST is LGFIFO minus one
	localparam int MAX_OUT = 1 << (LGFIFO - 1);
	localparam int MAXT = 32;
	// Cycles without a pixel before a test is abandoned
	localparam int IDLE_LIMIT = 2000;

	logic			i_clk = 1'b0;
	logic			i_reset;
	logic	[AW-1:0]	i_baseaddr;
	logic	[LGFRAME-1:0]	i_mem_words;
	logic	[LGFRAME-1:0]	i_height;
	logic			i_wb_stall;
	logic			i_wb_ack;
	logic	[DW-1:0]	i_wb_data;
	logic			i_vid_ready;
	wire			o_wb_cyc;
	wire			o_wb_stb;
	wire	[AW-1:0]	o_wb_addr;
	wire			o_vid_valid;
	wire	[PW-1:0]	o_vid_data;
	wire			o_vid_last;
	wire			o_vid_user;

	// Six hex fields per test
	logic	[31:0]		vectors [0:6*MAXT-1];
	// Memory model, requests still waiting for their ack
	logic	[AW-1:0]	ack_addr [$];
	int			errors;
	int			tests;
	int			total_pixels;
	bit			timed_out;

	vid_framebuf #(
		.AW(AW), .DW(DW), .PW(PW), .LGFRAME(LGFRAME), .LGFIFO(LGFIFO)
	) DUT (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_baseaddr(i_baseaddr), .i_mem_words(i_mem_words), .i_height(i_height),
		.o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_addr(o_wb_addr),
		.i_wb_stall(i_wb_stall), .i_wb_ack(i_wb_ack), .i_wb_data(i_wb_data),
		.o_vid_valid(o_vid_valid), .i_vid_ready(i_vid_ready),
		.o_vid_data(o_vid_data), .o_vid_last(o_vid_last), .o_vid_user(o_vid_user)
	);

	always #20 i_clk = ~i_clk;

	//////////////////////////////
	// Reporting
	//////////////////////////////

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		errors++;
		$display("[ERROR] t=%0t %s expected %h got %h", $time, name, expected, actual);
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("Failure at t=%0t: %s", $time, what);
	endtask

	//////////////////////////////
	// One test
	//////////////////////////////

	task automatic run_test(input logic [AW-1:0] base, input int words, input int height,
		input int frames, input int stall_pct, input int ready_pct);
		int		idle;
		int		ack_wait;
		int		frames_done;
		int		pixels;
		int		req_h;
		int		req_v;
		int		pix_h;
		int		pix_v;
		int		pix_p;
		int		start_errors;
		logic [DW-1:0]	exp_word;
		logic [PW-1:0]	exp_pix;
		logic [AW-1:0]	exp_addr;
		logic		exp_last;
		logic		exp_user;
		logic		stalled;
		logic [PW-1:0]	held_data;
		logic		held_last;
		logic		held_user;

		idle = 0;
		ack_wait = 0;
		frames_done = 0;
		pixels = 0;
		req_h = 0;
		req_v = 0;
		pix_h = 0;
		pix_v = 0;
		pix_p = 0;
		stalled = 1'b0;
		held_data = '0;
		held_last = 1'b0;
		held_user = 1'b0;
		start_errors = errors;
		// Geometry goes in under reset
		i_reset = 1'b1;
		i_wb_stall = 1'b0;
		i_wb_ack = 1'b0;
		i_wb_data = '0;
		i_vid_ready = 1'b0;
		i_baseaddr = base;
		i_mem_words = LGFRAME'(words);
		i_height = LGFRAME'(height);
		ack_addr.delete();
		repeat (10) @(posedge i_clk);
		#1;
		// Bus and stream quiet in reset
		if (o_wb_cyc !== 1'b0 || o_wb_stb !== 1'b0 || o_vid_valid !== 1'b0
			|| o_vid_last !== 1'b0)
			report_failure("bus or stream outputs active during reset");
		i_reset = 1'b0;

		while (frames_done < frames && !timed_out)
		begin
			@(posedge i_clk);
			#1;
			idle++;
			// Slave side, random stall and in-order acks
			i_wb_stall = (($urandom % 100) < stall_pct);
			i_wb_ack = 1'b0;
			if (!o_wb_cyc && ack_addr.size() > 0)
				report_failure("cyc dropped with requests still outstanding");
			if (ack_addr.size() > 0)
			begin
				if (ack_wait > 0)
					ack_wait--;
				else
				begin
					i_wb_ack = 1'b1;
					i_wb_data = {8'h00, ack_addr[0]} + 32'hA500_0000;
					ack_addr.delete(0);
					// Gap before the next ack
					ack_wait = int'($urandom % 4);
				end
			end
			if (o_wb_stb && !o_wb_cyc)
				report_failure("stb high while cyc low");
			// Request taken on the coming edge
			if (o_wb_stb && !i_wb_stall)
			begin
				exp_addr = base + AW'(req_v * words + req_h);
				if (o_wb_addr < base || o_wb_addr > base + AW'(words * height - 1))
					report_failure("request address outside the frame");
				if (o_wb_addr !== exp_addr)
					report_mismatch("o_wb_addr", 32'(exp_addr), 32'(o_wb_addr));
				ack_addr.push_back(o_wb_addr);
				if (req_h == words - 1)
				begin
					req_h = 0;
					req_v = (req_v == height - 1) ? 0 : req_v + 1;
				end
				else
					req_h++;
			end
			if (ack_addr.size() > MAX_OUT)
				report_failure("more requests outstanding than one burst allows");

			// Video side
			i_vid_ready = (($urandom % 100) < ready_pct);
			// A stalled beat holds
			if (stalled)
			begin
				if (!o_vid_valid)
					report_failure("valid dropped while the stream was stalled");
				if (o_vid_data !== held_data)
					report_mismatch("o_vid_data", 32'(held_data), 32'(o_vid_data));
				if (o_vid_last !== held_last)
					report_mismatch("o_vid_last", 32'(held_last), 32'(o_vid_last));
				if (o_vid_user !== held_user)
					report_mismatch("o_vid_user", 32'(held_user), 32'(o_vid_user));
			end
			if (o_vid_valid && i_vid_ready)
			begin
				idle = 0;
				exp_word = {8'h00, base + AW'(pix_v * words + pix_h)} + 32'hA500_0000;
				// Top pixel first
				exp_pix = PW'(exp_word >> (DW - PW - pix_p * PW));
				exp_last = (pix_h == words - 1) && (pix_p == NPIX - 1);
				exp_user = (pix_h == 0) && (pix_v == 0) && (pix_p == 0);
				if (o_vid_data !== exp_pix)
					report_mismatch("o_vid_data", 32'(exp_pix), 32'(o_vid_data));
				if (o_vid_last !== exp_last)
					report_mismatch("o_vid_last", 32'(exp_last), 32'(o_vid_last));
				if (o_vid_user !== exp_user)
					report_mismatch("o_vid_user", 32'(exp_user), 32'(o_vid_user));
				pixels++;
				if (pix_p < NPIX - 1)
					pix_p++;
				else
				begin
					pix_p = 0;
					if (pix_h < words - 1)
						pix_h++;
					else
					begin
						pix_h = 0;
						if (pix_v < height - 1)
							pix_v++;
						else
						begin
							// Frame done, next one starts at the base
							pix_v = 0;
							frames_done++;
						end
					end
				end
			end
			stalled = o_vid_valid && !i_vid_ready;
			held_data = o_vid_data;
			held_last = o_vid_last;
			held_user = o_vid_user;
			if (idle > IDLE_LIMIT)
			begin
				report_failure("timeout, no pixel came out for too long");
				timed_out = 1'b1;
			end
		end
		total_pixels += pixels;
		$display("Test %0d: base %h, %0d words x %0d lines, %0d frames, %0d pixels, %0s",
			tests, base, words, height, frames_done, pixels,
			(errors == start_errors) ? "passed" : "failed");
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial
	begin
		int t;

		void'($urandom(32'h938b_f302));
		errors = 0;
		tests = 0;
		total_pixels = 0;
		timed_out = 1'b0;
		i_reset = 1'b1;
		i_baseaddr = '0;
		i_mem_words = '0;
		i_height = '0;
		i_wb_stall = 1'b0;
		i_wb_ack = 1'b0;
		i_wb_data = '0;
		i_vid_ready = 1'b0;
		for (t = 0; t < 6 * MAXT; t++)
			vectors[t] = '0;
		$readmemh("bench/vid_framebuf_vectors.txt", vectors);
		// Zero words per line ends the table
		t = 0;
		while (t < MAXT && vectors[6*t+1] != 0 && !timed_out)
		begin
			tests++;
			run_test(AW'(vectors[6*t]), int'(vectors[6*t+1]), int'(vectors[6*t+2]),
				int'(vectors[6*t+3]), int'(vectors[6*t+4]), int'(vectors[6*t+5]));
			t++;
		end
		if (tests == 0)
			report_failure("no test vectors were read");
		$display("Tests %0d, pixels checked %0d, errors %0d", tests, total_pixels, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/vid_framebuf_vectors.txt */
// Columns, all hex: base address, words per line, lines per frame,
// frames to check, stall percent, ready percent
// A line of zeros ends the table
000100 04 03 3 00 64
// Smallest frame
000000 02 02 4 00 64
// Lines longer than one burst
001000 28 05 2 00 64
0FFF00 10 04 2 32 64
002000 08 06 2 00 32
003000 21 03 2 46 1E
004000 40 02 2 0A 5A
005000 03 07 3 32 32
// Heavy back-pressure
006000 11 03 2 00 0A
FFFF00 05 04 2 1E 50
000000 00 00 0 00 00

/* hw/fb_pkg.sv */
`default_nettype none

package fb_pkg;

	//////////////////////////////
	// Default geometry
	//////////////////////////////

	// Word address width on the bus
	localparam int DEF_AW = 24;
	// Bus data width
	localparam int DEF_DW = 32;
	// Pixel width, must divide the bus width
	localparam int DEF_PW = 8;
	// Width of the line length and height inputs
	localparam int DEF_LGFRAME = 11;
	// Log2 of the pixel FIFO depth
	localparam int DEF_LGFIFO = 6;

	//////////////////////////////
	// Word tags
	//////////////////////////////

	// Flags carried beside each fetched word
	localparam int TAG_W = 2;
	// Last word of a line
	localparam int TAG_EOL = 0;
	// Last word of a frame
	localparam int TAG_EOF = 1;

	// Request engine state
	typedef enum logic [1:0] {
		BUS_IDLE,
		BUS_REQUEST,
		BUS_DRAIN
	} bus_state_t;

endpackage

`default_nettype wire

/* hw/pixel_fifo.sv */
`default_nettype none

module pixel_fifo #(
	parameter int DW     = fb_pkg::DEF_DW,
	parameter int LGFIFO = fb_pkg::DEF_LGFIFO
) (
	input  wire                      i_clk,
	input  wire                      i_reset,
	// Write side
	input  wire                      i_wr,
	input  wire [DW-1:0]             i_wr_data,
	input  wire [fb_pkg::TAG_W-1:0]  i_wr_tag,
	output logic [LGFIFO:0]          o_fill,
	// Read side, head word registered
	input  wire                      i_rd,
	output logic                     o_empty,
	output logic [DW-1:0]            o_rd_data,
	output logic [fb_pkg::TAG_W-1:0] o_rd_tag
);

	localparam int BW = DW + fb_pkg::TAG_W;
	localparam int DEPTH = 1 << LGFIFO;

	logic	[BW-1:0]	mem [0:DEPTH-1];
	logic	[BW-1:0]	head;
	logic	[LGFIFO-1:0]	wr_ptr, rd_ptr, rd_next;
	logic	[LGFIFO:0]	fill;
	logic			w_rd;

	assign w_rd = i_rd && !o_empty;
	assign rd_next = rd_ptr + 1'b1;

	always_ff @(posedge i_clk or posedge i_reset)
	begin
		if (i_reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end
		else
		begin
			if (i_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (w_rd)
				rd_ptr <= rd_next;
			case ({ i_wr, w_rd })
			2'b10: fill <= fill + 1'b1;
			2'b01: fill <= fill - 1'b1;
			default: fill <= fill;
			endcase
		end
	end

	// Data and tag side by side
	always_ff @(posedge i_clk)
	begin
		if (i_wr)
			mem[wr_ptr] <= { i_wr_tag, i_wr_data };
	end

	// Head register, bypassed when the FIFO runs dry
	always_ff @(posedge i_clk)
	begin
		if (i_wr && (fill == '0 || (w_rd && fill == (LGFIFO+1)'(1))))
			head <= { i_wr_tag, i_wr_data };
		else if (w_rd)
			head <= mem[rd_next];
	end

	assign o_fill = fill;
	assign o_empty = (fill == '0);
	assign o_rd_data = head[DW-1:0];
	assign o_rd_tag = head[DW +: fb_pkg::TAG_W];

	// Reader must keep room for every word in flight
	assert property (@(posedge i_clk) disable iff (i_reset)
		i_wr |-> (fill != (LGFIFO+1)'(DEPTH)));

endmodule

`default_nettype wire

/* hw/pixel_unpacker.sv */
`default_nettype none

module pixel_unpacker #(
	parameter int DW = fb_pkg::DEF_DW,
	parameter int PW = fb_pkg::DEF_PW
) (
	input  wire                     i_clk,
	input  wire                     i_reset,
	// FIFO read side
	input  wire                     i_empty,
	input  wire [DW-1:0]            i_rd_data,
	input  wire [fb_pkg::TAG_W-1:0] i_rd_tag,
	output logic                    o_rd,
	// Video stream
	output logic                    o_vid_valid,
	input  wire                     i_vid_ready,
	output logic [PW-1:0]           o_vid_data,
	output logic                    o_vid_last,
	output logic                    o_vid_user
);

	// Pixels per bus word
	localparam int NPIX = DW / PW;
	localparam int CW = $clog2(NPIX + 1);

	logic	[CW-1:0]		px_count;
	logic	[DW-1:0]		px_sreg;
	logic	[fb_pkg::TAG_W-1:0]	px_tag;
	logic				sof;
	logic				xfer;
	logic				load;
	logic				px_final;

	//////////////////////////////
	// Word fetch
	//////////////////////////////

	assign o_vid_valid = (px_count != '0);
	assign xfer = o_vid_valid && i_vid_ready;
	// Last pixel of the held word
	assign px_final = (px_count == CW'(1));

	// Refill when empty or as the final pixel leaves
	assign o_rd = !o_vid_valid || (xfer && px_final);
	assign load = o_rd && !i_empty;

	always_ff @(posedge i_clk or posedge i_reset)
	begin
		if (i_reset)
			px_count <= '0;
		else if (load)
			px_count <= CW'(NPIX);
		else if (xfer)
			px_count <= px_count - 1'b1;
	end

	// Shift left, next pixel moves to the top
	always_ff @(posedge i_clk)
	begin
		if (load)
		begin
			px_sreg <= i_rd_data;
			px_tag  <= i_rd_tag;
		end
		else if (xfer)
			px_sreg <= { px_sreg[DW-PW-1:0], {PW{1'b0}} };
	end

	//////////////////////////////
	// Stream flags
	//////////////////////////////

	// Start of frame pending
	always_ff @(posedge i_clk or posedge i_reset)
	begin
		if (i_reset)
			sof <= 1'b1;
		else if (xfer)
			sof <= o_vid_last && px_tag[fb_pkg::TAG_EOF];
	end

	assign o_vid_data = px_sreg[DW-1 -: PW];
	assign o_vid_last = px_final && px_tag[fb_pkg::TAG_EOL];
	assign o_vid_user = sof;

	// Stalled beat holds until taken
	assert property (@(posedge i_clk) disable iff (i_reset)
		(o_vid_valid && !i_vid_ready) |=> (o_vid_valid && $stable(o_vid_data)
			&& $stable(o_vid_last) && $stable(o_vid_user)));

endmodule

`default_nettype wire

/* hw/vid_framebuf.sv */
`default_nettype none

module vid_framebuf #(
	parameter int AW      = fb_pkg::DEF_AW,
	parameter int DW      = fb_pkg::DEF_DW,
	parameter int PW      = fb_pkg::DEF_PW,
	parameter int LGFRAME = fb_pkg::DEF_LGFRAME,
	parameter int LGFIFO  = fb_pkg::DEF_LGFIFO,
	parameter int LGBURST = LGFIFO - 1
) (
	input  wire               i_clk,
	input  wire               i_reset,
	// Frame geometry, held stable outside reset
	input  wire [AW-1:0]      i_baseaddr,
	input  wire [LGFRAME-1:0] i_mem_words,
	input  wire [LGFRAME-1:0] i_height,
	// Wishbone
	output logic              o_wb_cyc,
	output logic              o_wb_stb,
	output logic [AW-1:0]     o_wb_addr,
	input  wire               i_wb_stall,
	input  wire               i_wb_ack,
	input  wire [DW-1:0]      i_wb_data,
	// Video stream
	output logic              o_vid_valid,
	input  wire               i_vid_ready,
	output logic [PW-1:0]     o_vid_data,
	output logic              o_vid_last,
	output logic              o_vid_user
);

	logic	[LGFIFO:0]		fifo_fill;
	logic				fifo_wr;
	logic	[DW-1:0]		fifo_wr_data;
	logic	[fb_pkg::TAG_W-1:0]	fifo_wr_tag;
	logic				fifo_rd;
	logic				fifo_empty;
	logic	[DW-1:0]		fifo_rd_data;
	logic	[fb_pkg::TAG_W-1:0]	fifo_rd_tag;

	// Bus requests and tagging
	wb_frame_reader #(
		.AW(AW), .DW(DW), .LGFRAME(LGFRAME),
		.LGFIFO(LGFIFO), .LGBURST(LGBURST)
	) u_reader (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_baseaddr(i_baseaddr), .i_mem_words(i_mem_words), .i_height(i_height),
		.o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_addr(o_wb_addr),
		.i_wb_stall(i_wb_stall), .i_wb_ack(i_wb_ack), .i_wb_data(i_wb_data),
		.i_fill(fifo_fill), .o_wr(fifo_wr),
		.o_wr_data(fifo_wr_data), .o_wr_tag(fifo_wr_tag)
	);

	// Word buffer
	pixel_fifo #(
		.DW(DW), .LGFIFO(LGFIFO)
	) u_fifo (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_wr(fifo_wr), .i_wr_data(fifo_wr_data), .i_wr_tag(fifo_wr_tag),
		.o_fill(fifo_fill),
		.i_rd(fifo_rd), .o_empty(fifo_empty),
		.o_rd_data(fifo_rd_data), .o_rd_tag(fifo_rd_tag)
	);

	// Words to pixels
	pixel_unpacker #(
		.DW(DW), .PW(PW)
	) u_unpack (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_empty(fifo_empty), .i_rd_data(fifo_rd_data), .i_rd_tag(fifo_rd_tag),
		.o_rd(fifo_rd),
		.o_vid_valid(o_vid_valid), .i_vid_ready(i_vid_ready),
		.o_vid_data(o_vid_data), .o_vid_last(o_vid_last), .o_vid_user(o_vid_user)
	);

endmodule

`default_nettype wire

/* hw/wb_frame_reader.sv */
`default_nettype none

module wb_frame_reader #(
	parameter int AW      = fb_pkg::DEF_AW,
	parameter int DW      = fb_pkg::DEF_DW,
	parameter int LGFRAME = fb_pkg::DEF_LGFRAME,
	parameter int LGFIFO  = fb_pkg::DEF_LGFIFO,
	parameter int LGBURST = fb_pkg::DEF_LGFIFO - 1
) (
	input  wire                      i_clk,
	input  wire                      i_reset,
	// Frame geometry
	input  wire [AW-1:0]             i_baseaddr,
	input  wire [LGFRAME-1:0]        i_mem_words,
	input  wire [LGFRAME-1:0]        i_height,
	// Wishbone master, read only
	output logic                     o_wb_cyc,
	output logic                     o_wb_stb,
	output logic [AW-1:0]            o_wb_addr,
	input  wire                      i_wb_stall,
	input  wire                      i_wb_ack,
	input  wire [DW-1:0]             i_wb_data,
	// FIFO write side
	input  wire [LGFIFO:0]           i_fill,
	output logic                     o_wr,
	output logic [DW-1:0]            o_wr_data,
	output logic [fb_pkg::TAG_W-1:0] o_wr_tag
);

	fb_pkg::bus_state_t	bus_state;
	logic	[LGBURST:0]	outstanding;
	logic	[LGFIFO+1:0]	committed;
	logic			req_accept;
	logic			last_request;
	// Request side position
	logic	[LGFRAME-1:0]	wb_hpos, wb_vpos;
	logic			wb_hlast, wb_vlast;
	logic	[AW-1:0]	line_addr;
	// Return side position, one step per ack
	logic	[LGFRAME-1:0]	rx_hpos, rx_vpos;
	logic			rx_hlast, rx_vlast;

	//////////////////////////////
	// Request engine
	//////////////////////////////

	assign o_wb_cyc = (bus_state != fb_pkg::BUS_IDLE);
	assign o_wb_stb = (bus_state == fb_pkg::BUS_REQUEST);
	assign req_accept = o_wb_stb && !i_wb_stall;

	// Words in flight plus words stored, counting this request
	assign committed = (LGFIFO+2)'(outstanding) + (LGFIFO+2)'(i_fill) + 1'b1;

	// Request now on the bus closes the burst
	always_comb
	begin
		// Line end
		last_request = wb_hlast;
		// Burst length reached
		if (outstanding >= (LGBURST+1)'((1 << LGBURST) - 1))
			last_request = 1'b1;
		// No FIFO room for another word
		if (committed >= (LGFIFO+2)'(1 << LGFIFO))
			last_request = 1'b1;
	end

	always_ff @(posedge i_clk or posedge i_reset)
	begin
		if (i_reset)
			bus_state <= fb_pkg::BUS_IDLE;
		else
		begin
			case (bus_state)
			fb_pkg::BUS_IDLE:
				// Open only when the FIFO is under half full
				if (i_fill[LGFIFO:LGFIFO-1] == 2'b00)
					bus_state <= fb_pkg::BUS_REQUEST;
			fb_pkg::BUS_REQUEST:
				if (req_accept && last_request)
					bus_state <= fb_pkg::BUS_DRAIN;
			fb_pkg::BUS_DRAIN:
				// Final ack closes the cycle
				if (i_wb_ack && outstanding == (LGBURST+1)'(1))
					bus_state <= fb_pkg::BUS_IDLE;
			default:
				bus_state <= fb_pkg::BUS_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk or posedge i_reset)
	begin
		if (i_reset)
			outstanding <= '0;
		else if (!o_wb_cyc)
			outstanding <= '0;
		else
		begin
			case ({ req_accept, i_wb_ack })
			2'b10: outstanding <= outstanding + 1'b1;
			2'b01: outstanding <= outstanding - 1'b1;
			default: outstanding <= outstanding;
			endcase
		end
	end

	//////////////////////////////
	// Address walk
	//////////////////////////////

	always_ff @(posedge i_clk or posedge i_reset)
	begin
		if (i_reset)
		begin
			// Geometry sampled here
			o_wb_addr <= i_baseaddr;
			line_addr <= i_baseaddr + AW'(i_mem_words);
			wb_hpos   <= '0;
			wb_vpos   <= '0;
			wb_hlast  <= 1'b0;
			wb_vlast  <= 1'b0;
		end
		else if (req_accept)
		begin
			if (wb_hlast)
			begin
				wb_hpos  <= '0;
				wb_hlast <= 1'b0;
				if (wb_vlast)
				begin
					// Frame done, back to the base
					o_wb_addr <= i_baseaddr;
					line_addr <= i_baseaddr + AW'(i_mem_words);
					wb_vpos   <= '0;
					wb_vlast  <= 1'b0;
				end
				else
				begin
					o_wb_addr <= line_addr;
					line_addr <= line_addr + AW'(i_mem_words);
					wb_vpos   <= wb_vpos + 1'b1;
					wb_vlast  <= (wb_vpos == i_height - LGFRAME'(2));
				end
			end
			else
			begin
				o_wb_addr <= o_wb_addr + 1'b1;
				wb_hpos   <= wb_hpos + 1'b1;
				wb_hlast  <= (wb_hpos == i_mem_words - LGFRAME'(2));
			end
		end
	end

	//////////////////////////////
	// Return word tagging
	//////////////////////////////

	always_ff @(posedge i_clk or posedge i_reset)
	begin
		if (i_reset)
		begin
			rx_hpos  <= '0;
			rx_vpos  <= '0;
			rx_hlast <= 1'b0;
			rx_vlast <= 1'b0;
		end
		else if (!o_wb_cyc)
		begin
			// Idle, catch up with the request side
			rx_hpos  <= wb_hpos;
			rx_vpos  <= wb_vpos;
			rx_hlast <= wb_hlast;
			rx_vlast <= wb_vlast;
		end
		else if (i_wb_ack)
		begin
			if (rx_hlast)
			begin
				rx_hpos  <= '0;
				rx_hlast <= 1'b0;
				if (rx_vlast)
				begin
					rx_vpos  <= '0;
					rx_vlast <= 1'b0;
				end
				else
				begin
					rx_vpos  <= rx_vpos + 1'b1;
					rx_vlast <= (rx_vpos == i_height - LGFRAME'(2));
				end
			end
			else
			begin
				rx_hpos  <= rx_hpos + 1'b1;
				rx_hlast <= (rx_hpos == i_mem_words - LGFRAME'(2));
			end
		end
	end

	// Every ack lands in the FIFO
	assign o_wr = o_wb_cyc && i_wb_ack;
	assign o_wr_data = i_wb_data;
	assign o_wr_tag[fb_pkg::TAG_EOL] = rx_hlast;
	assign o_wr_tag[fb_pkg::TAG_EOF] = rx_hlast && rx_vlast;

	// Burst budget holds across the whole cycle
	assert property (@(posedge i_clk) disable iff (i_reset)
		outstanding <= (LGBURST+1)'(1 << LGBURST));

	assert property (@(posedge i_clk) disable iff (i_reset)
		(outstanding == (LGBURST+1)'(1 << LGBURST)) |-> !o_wb_stb);

	// Slave acks only what was requested
	assert property (@(posedge i_clk) disable iff (i_reset)
		i_wb_ack |-> (o_wb_cyc && outstanding != '0));

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the framebuffer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_vid_framebuf \
	-f vid_framebuf.f -o tb_vid_framebuf > build.log 2>&1 \
	|| { cat build.log; echo "FAIL: build"; exit 1; }
./obj_dir/tb_vid_framebuf > sim.log 2>&1
cat sim.log
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "No errors" sim.log && echo "PASS" || { echo "FAIL: run ended early"; exit 1; }

/* vid_framebuf.f */
hw/fb_pkg.sv
hw/wb_frame_reader.sv
hw/pixel_fifo.sv
hw/pixel_unpacker.sv
hw/vid_framebuf.sv
bench/tb_vid_framebuf.sv
